// File: src.f
source/mc_current_pkg.sv
source/mc_adc_clk_gen.sv
source/mc_sinc3_filter.sv
source/up_mc_channel.sv
source/up_mc_common.sv
source/mc_current_monitor.sv
dv/tb_mc_current_monitor.sv

// File: Makefile
TOP = tb_mc_current_monitor

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f src.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// File: dv/tb_mc_current_monitor.sv
// current monitor testbench with clock, reset and bus tasks
// modulator bitstream drivers, checks, watchdog and report

`timescale 1ns/1ps

module tb_mc_current_monitor
    import mc_current_pkg::*;
();

    localparam int ADC_CLK_DIV = 4;
    localparam int DEC_RATE    = 32;
    localparam int CLK_NS      = 20;
    localparam int WORD_CYCLES = DEC_RATE * ADC_CLK_DIV;
    // warm-up and measurement windows of all tests plus bus traffic
    localparam int TEST_CYCLES = 40 * WORD_CYCLES;
    localparam int PAT_ZEROS   = 0;
    localparam int PAT_ONES    = 1;
    localparam int PAT_ALT     = 2;

    logic     up_clk;
    logic     up_rstn;
    logic     mod_bit [3];
    int       pattern [3];
    logic     adc_clk;
    logic     adc_enable [3];
    sample_t  ia;
    sample_t  ib;
    sample_t  vbus;
    logic     i_ready;
    logic     up_wreq;
    up_addr_t up_waddr;
    up_data_t up_wdata;
    logic     up_wack;
    logic     up_rreq;
    up_addr_t up_raddr;
    up_data_t up_rdata;
    logic     up_rack;

    string       cur_test;
    int          test_cnt;
    int          check_cnt;
    int          err_cnt;
    int          test_err_start;
    logic [31:0] rng_state;

    mc_current_monitor #(
        .ADC_CLK_DIV (ADC_CLK_DIV),
        .DEC_RATE    (DEC_RATE)
    ) u_mc_current_monitor (
        .up_clk            (up_clk),
        .up_rstn           (up_rstn),
        .adc_ia_dat_i      (mod_bit[0]),
        .adc_ib_dat_i      (mod_bit[1]),
        .adc_vbus_dat_i    (mod_bit[2]),
        .adc_clk_o         (adc_clk),
        .adc_enable_ia_o   (adc_enable[0]),
        .adc_enable_ib_o   (adc_enable[1]),
        .adc_enable_vbus_o (adc_enable[2]),
        .ia_o              (ia),
        .ib_o              (ib),
        .vbus_o            (vbus),
        .i_ready_o         (i_ready),
        .up_wreq_i         (up_wreq),
        .up_waddr_i        (up_waddr),
        .up_wdata_i        (up_wdata),
        .up_wack_o         (up_wack),
        .up_rreq_i         (up_rreq),
        .up_raddr_i        (up_raddr),
        .up_rdata_o        (up_rdata),
        .up_rack_o         (up_rack)
    );

    initial
    begin
        up_clk = 1'b0;
        forever #(CLK_NS / 2) up_clk = ~up_clk;
    end

    // each acknowledge exactly two cycles after its request
    write_ack_latency: assert property (@(posedge up_clk) disable iff (!up_rstn)
        up_wack === $past(up_wreq, 2))
    else
    begin
        $display("write acknowledge not 2 cycles after its request at %0t", $time);
        err_cnt++;
    end

    read_ack_latency: assert property (@(posedge up_clk) disable iff (!up_rstn)
        up_rack === $past(up_rreq, 2))
    else
    begin
        $display("read acknowledge not 2 cycles after its request at %0t", $time);
        err_cnt++;
    end

    // **************************************************
    // helpers
    // **************************************************

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // density times DEC_RATE cubed
    // a full density stream saturates to the largest code
    function automatic sample_t expected_word(input int pat);
        longint num;
        longint den;
        longint w;
        num = (pat == PAT_ZEROS) ? 0 : 1;
        den = (pat == PAT_ALT) ? 2 : 1;
        w = num * DEC_RATE * DEC_RATE * DEC_RATE / den;
        if (num == den || w > 65535)
        begin
            w = 65535;
        end
        return sample_t'(w);
    endfunction

    function automatic up_addr_t chan_addr(input int ch, input logic [3:0] off);
        return MC_CHAN_BASE + up_addr_t'(16 * ch) + up_addr_t'(off);
    endfunction

    function automatic sample_t data_output(input int ch);
        case (ch)
            0:       return ia;
            1:       return ib;
            default: return vbus;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        assert (act === exp)
        else
        begin
            $display("mismatch %s %s: expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        check_cnt++;
        assert (cond)
        else
        begin
            $display("%s: %s", cur_test, msg);
            err_cnt++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = err_cnt;
    endtask

    task automatic end_test();
        test_cnt++;
        $display("%-18s done, %0d errors", cur_test, err_cnt - test_err_start);
    endtask

    task automatic bus_write(input up_addr_t addr, input up_data_t data);
        int n;
        @(negedge up_clk);
        up_wreq  = 1'b1;
        up_waddr = addr;
        up_wdata = data;
        @(negedge up_clk);
        up_wreq = 1'b0;
        n = 0;
        while (!up_wack && n < 8)
        begin
            @(negedge up_clk);
            n++;
        end
        check_true(up_wack, $sformatf("no write acknowledge for address 0x%0h", addr));
    endtask

    task automatic bus_read(input up_addr_t addr, output up_data_t data);
        int n;
        @(negedge up_clk);
        up_rreq  = 1'b1;
        up_raddr = addr;
        @(negedge up_clk);
        up_rreq = 1'b0;
        n = 0;
        while (!up_rack && n < 8)
        begin
            @(negedge up_clk);
            n++;
        end
        check_true(up_rack, $sformatf("no read acknowledge for address 0x%0h", addr));
        data = up_rdata;
    endtask

    task automatic wait_status(input int ch);
        up_data_t rd;
        int       n;
        rd = '0;
        n  = 0;
        while (!rd[0] && n < WORD_CYCLES * 2)
        begin
            bus_read(chan_addr(ch, REG_CHAN_STATUS), rd);
            n++;
        end
        check_true(rd[0], $sformatf("status of channel %0d never set", ch));
    endtask

    task automatic wait_ready(input int max_cycles, output int cycles, output logic found);
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < max_cycles)
        begin
            @(negedge up_clk);
            cycles++;
            found = i_ready;
        end
    endtask

    task automatic count_ready_pulses(input int cycles, output int pulses);
        pulses = 0;
        repeat (cycles)
        begin
            @(negedge up_clk);
            if (i_ready)
            begin
                pulses++;
            end
        end
    endtask

    // next bit goes out on the falling edge after each bit clock rise
    task automatic drive_bitstream(input int ch);
        logic phase;
        phase = 1'b0;
        forever
        begin
            @(posedge adc_clk);
            @(negedge up_clk);
            phase = ~phase;
            case (pattern[ch])
                PAT_ZEROS: mod_bit[ch] = 1'b0;
                PAT_ONES:  mod_bit[ch] = 1'b1;
                default:   mod_bit[ch] = phase;
            endcase
        end
    endtask

    initial drive_bitstream(0);
    initial drive_bitstream(1);
    initial drive_bitstream(2);

    initial
    begin : watchdog
        repeat (5 * TEST_CYCLES) @(posedge up_clk);
        $display("watchdog expired after %0d cycles", 5 * TEST_CYCLES);
        $display("test failed");
        $finish;
    end

    // **************************************************
    // test sequence
    // **************************************************

    initial
    begin : main
        up_data_t rd;
        time      t0;
        time      t1;
        int       cycles;
        int       pulses;
        logic     found;

        up_rstn   = 1'b0;
        up_wreq   = 1'b0;
        up_waddr  = '0;
        up_wdata  = '0;
        up_rreq   = 1'b0;
        up_raddr  = '0;
        test_cnt  = 0;
        check_cnt = 0;
        err_cnt   = 0;
        rng_state = 32'ha47591a8;
        for (int ch = 0; ch < 3; ch++)
        begin
            mod_bit[ch] = 1'b0;
            pattern[ch] = PAT_ZEROS;
        end
        repeat (2) @(posedge up_clk);
        @(negedge up_clk);
        up_rstn = 1'b1;

        start_test("reset_values");
        for (int ch = 0; ch < 3; ch++)
        begin
            check_value($sformatf("adc_enable[%0d]", ch), 0, adc_enable[ch]);
            check_value($sformatf("data output %0d", ch), 0, data_output(ch));
        end
        check_value("i_ready_o", 0, i_ready);
        bus_read(MC_COMMON_BASE + up_addr_t'(REG_VERSION), rd);
        check_value("version", MC_VERSION, rd);
        bus_read(MC_COMMON_BASE + up_addr_t'(REG_CHAN_COUNT), rd);
        check_value("channel count", 3, rd);
        bus_read(MC_COMMON_BASE + up_addr_t'(REG_ADC_RSTN), rd);
        check_value("adc reset bit", 0, rd);
        @(posedge adc_clk);
        t0 = $time;
        @(posedge adc_clk);
        t1 = $time;
        check_value("adc_clk period ns", ADC_CLK_DIV * CLK_NS, 32'(t1 - t0));
        end_test();

        start_test("scratch");
        repeat (8)
        begin
            rng_state = next_random(rng_state);
            bus_write(MC_COMMON_BASE + up_addr_t'(REG_SCRATCH), rng_state);
            bus_read(MC_COMMON_BASE + up_addr_t'(REG_SCRATCH), rd);
            check_value("scratch", rng_state, rd);
        end
        end_test();

        // phase a zeros, phase b alternating, vbus ones into saturation
        start_test("conversion");
        pattern[0] = PAT_ZEROS;
        pattern[1] = PAT_ALT;
        pattern[2] = PAT_ONES;
        bus_write(MC_COMMON_BASE + up_addr_t'(REG_ADC_RSTN), 1);
        for (int ch = 0; ch < 3; ch++)
        begin
            bus_write(chan_addr(ch, REG_CHAN_CTRL), 1);
            check_value($sformatf("adc_enable[%0d]", ch), 1, adc_enable[ch]);
        end
        for (int ch = 0; ch < 3; ch++)
        begin
            wait_status(ch);
            check_value($sformatf("data output %0d", ch), expected_word(pattern[ch]),
                        data_output(ch));
            bus_read(chan_addr(ch, REG_CHAN_DATA), rd);
            check_value($sformatf("data register %0d", ch), expected_word(pattern[ch]), rd);
        end
        end_test();

        start_test("ready_timing");
        bus_write(chan_addr(0, REG_CHAN_CTRL), 0);
        check_value("adc_enable[0]", 0, adc_enable[0]);
        count_ready_pulses(4 * WORD_CYCLES, pulses);
        check_value("pulses while disabled", 0, pulses);
        bus_write(chan_addr(0, REG_CHAN_CTRL), 1);
        wait_ready(4 * WORD_CYCLES, cycles, found);
        check_true(found, "no i_ready_o pulse after enabling phase a");
        check_true(cycles >= 3 * WORD_CYCLES - ADC_CLK_DIV &&
                   cycles <= 3 * WORD_CYCLES + ADC_CLK_DIV,
                   $sformatf("first i_ready_o pulse after %0d cycles, not after warm-up",
                             cycles));
        repeat (3)
        begin
            wait_ready(WORD_CYCLES + ADC_CLK_DIV, cycles, found);
            check_value("i_ready_o interval", WORD_CYCLES, cycles);
        end
        end_test();

        start_test("disable_and_reset");
        bus_write(chan_addr(1, REG_CHAN_CTRL), 0);
        bus_read(chan_addr(1, REG_CHAN_STATUS), rd);
        check_value("status 1 after disable", 0, rd);
        pattern[1] = PAT_ONES;
        pattern[2] = PAT_ALT;
        count_ready_pulses(5 * WORD_CYCLES, pulses);
        check_true(pulses >= 4, $sformatf("phase a gave only %0d words", pulses));
        check_value("ib_o held", expected_word(PAT_ALT), ib);
        check_value("vbus_o updated", expected_word(PAT_ALT), vbus);
        bus_read(chan_addr(1, REG_CHAN_STATUS), rd);
        check_value("status 1 while disabled", 0, rd);

        // converter reset freezes every channel
        bus_write(MC_COMMON_BASE + up_addr_t'(REG_ADC_RSTN), 0);
        pattern[0] = PAT_ONES;
        pattern[2] = PAT_ZEROS;
        count_ready_pulses(5 * WORD_CYCLES, pulses);
        check_value("pulses in converter reset", 0, pulses);
        check_value("ia_o held", expected_word(PAT_ZEROS), ia);
        check_value("vbus_o held", expected_word(PAT_ALT), vbus);

        bus_write(MC_COMMON_BASE + up_addr_t'(REG_ADC_RSTN), 1);
        wait_ready(4 * WORD_CYCLES, cycles, found);
        check_true(found, "no i_ready_o pulse after converter reset release");
        check_true(cycles >= 3 * WORD_CYCLES - ADC_CLK_DIV,
                   $sformatf("i_ready_o after %0d cycles, warm-up skipped", cycles));
        check_value("ia_o after restart", expected_word(PAT_ONES), ia);
        check_value("vbus_o after restart", expected_word(PAT_ZEROS), vbus);
        bus_write(chan_addr(1, REG_CHAN_CTRL), 1);
        wait_status(1);
        check_value("ib_o after enable", expected_word(PAT_ONES), ib);
        for (int ch = 0; ch < 3; ch++)
        begin
            bus_read(chan_addr(ch, REG_CHAN_DATA), rd);
            check_value($sformatf("data register %0d", ch), expected_word(pattern[ch]), rd);
        end
        end_test();

        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: source/mc_current_monitor.sv
// current and bus voltage monitor top level
// bit clock divider, three sinc3 channels, register blocks, bus response

`timescale 1ns/1ps

module mc_current_monitor
    import mc_current_pkg::*;
#(
    parameter int ADC_CLK_DIV = 4,
    parameter int DEC_RATE    = 32
) (
    input  logic     up_clk,
    input  logic     up_rstn,

    // modulator side
    input  logic     adc_ia_dat_i,
    input  logic     adc_ib_dat_i,
    input  logic     adc_vbus_dat_i,
    output logic     adc_clk_o,
    output logic     adc_enable_ia_o,
    output logic     adc_enable_ib_o,
    output logic     adc_enable_vbus_o,

    // decimated words
    output sample_t  ia_o,
    output sample_t  ib_o,
    output sample_t  vbus_o,
    output logic     i_ready_o,

    // processor bus
    input  logic     up_wreq_i,
    input  up_addr_t up_waddr_i,
    input  up_data_t up_wdata_i,
    output logic     up_wack_o,
    input  logic     up_rreq_i,
    input  up_addr_t up_raddr_i,
    output up_data_t up_rdata_o,
    output logic     up_rack_o
);

    logic     bit_strobe;
    logic     adc_rst;
    logic     mdata      [MC_NUM_CHANNELS];
    logic     adc_enable [MC_NUM_CHANNELS];
    sample_t  adc_data   [MC_NUM_CHANNELS];
    logic     data_ready [MC_NUM_CHANNELS];
    logic     wack_chan  [MC_NUM_CHANNELS];
    logic     rack_chan  [MC_NUM_CHANNELS];
    up_data_t rdata_chan [MC_NUM_CHANNELS];
    logic     wack_common;
    logic     rack_common;
    up_data_t rdata_common;
    logic     wack_any;
    logic     rack_any;
    up_data_t rdata_any;

    // channel order: phase a, phase b, bus voltage
    assign mdata[0] = adc_ia_dat_i;
    assign mdata[1] = adc_ib_dat_i;
    assign mdata[2] = adc_vbus_dat_i;

    assign adc_enable_ia_o   = adc_enable[0];
    assign adc_enable_ib_o   = adc_enable[1];
    assign adc_enable_vbus_o = adc_enable[2];
    assign ia_o              = adc_data[0];
    assign ib_o              = adc_data[1];
    assign vbus_o            = adc_data[2];
    assign i_ready_o         = data_ready[0];

    mc_adc_clk_gen #(
        .ADC_CLK_DIV (ADC_CLK_DIV)
    ) u_clk_gen (
        .up_clk       (up_clk),
        .up_rstn      (up_rstn),
        .adc_clk_o    (adc_clk_o),
        .bit_strobe_o (bit_strobe)
    );

    // **************************************************
    // converter channels
    // **************************************************

    for (genvar i = 0; i < MC_NUM_CHANNELS; i++)
    begin : gen_chan
        mc_sinc3_filter #(
            .DEC_RATE (DEC_RATE)
        ) u_filter (
            .up_clk       (up_clk),
            .up_rstn      (up_rstn),
            .adc_rst_i    (adc_rst),
            .enable_i     (adc_enable[i]),
            .bit_strobe_i (bit_strobe),
            .adc_mdata_i  (mdata[i]),
            .data_o       (adc_data[i]),
            .data_ready_o (data_ready[i])
        );

        up_mc_channel #(
            .CHANNEL_ID (i)
        ) u_channel (
            .up_clk           (up_clk),
            .up_rstn          (up_rstn),
            .up_wreq_i        (up_wreq_i),
            .up_waddr_i       (up_waddr_i),
            .up_wdata_i       (up_wdata_i),
            .up_wack_o        (wack_chan[i]),
            .up_rreq_i        (up_rreq_i),
            .up_raddr_i       (up_raddr_i),
            .up_rdata_o       (rdata_chan[i]),
            .up_rack_o        (rack_chan[i]),
            .adc_data_i       (adc_data[i]),
            .adc_data_ready_i (data_ready[i]),
            .adc_enable_o     (adc_enable[i])
        );
    end

    up_mc_common u_common (
        .up_clk     (up_clk),
        .up_rstn    (up_rstn),
        .up_wreq_i  (up_wreq_i),
        .up_waddr_i (up_waddr_i),
        .up_wdata_i (up_wdata_i),
        .up_wack_o  (wack_common),
        .up_rreq_i  (up_rreq_i),
        .up_raddr_i (up_raddr_i),
        .up_rdata_o (rdata_common),
        .up_rack_o  (rack_common),
        .adc_rst_o  (adc_rst)
    );

    // **************************************************
    // bus response, unselected blocks drive zeros
    // **************************************************

    always_comb
    begin
        wack_any  = wack_common;
        rack_any  = rack_common;
        rdata_any = rdata_common;
        for (int i = 0; i < MC_NUM_CHANNELS; i++)
        begin
            wack_any  = wack_any | wack_chan[i];
            rack_any  = rack_any | rack_chan[i];
            rdata_any = rdata_any | rdata_chan[i];
        end
    end

    always_ff @(posedge up_clk)
    begin
        if (!up_rstn)
        begin
            up_wack_o  <= 1'b0;
            up_rack_o  <= 1'b0;
            up_rdata_o <= '0;
        end
        else
        begin
            up_wack_o  <= wack_any;
            up_rack_o  <= rack_any;
            up_rdata_o <= rdata_any;
        end
    end

endmodule

// File: source/up_mc_common.sv
// common registers: version, scratch, converter reset, channel count

`timescale 1ns/1ps

module up_mc_common
    import mc_current_pkg::*;
(
    input  logic     up_clk,
    input  logic     up_rstn,
    input  logic     up_wreq_i,
    input  up_addr_t up_waddr_i,
    input  up_data_t up_wdata_i,
    output logic     up_wack_o,
    input  logic     up_rreq_i,
    input  up_addr_t up_raddr_i,
    output up_data_t up_rdata_o,
    output logic     up_rack_o,
    output logic     adc_rst_o
);

    logic     wsel;
    logic     rsel;
    up_data_t scratch;
    logic     adc_rstn;

    assign wsel = (up_waddr_i[13:4] == MC_COMMON_BASE[13:4]) &&
                  (up_waddr_i[3:0] <= REG_CHAN_COUNT);
    assign rsel = (up_raddr_i[13:4] == MC_COMMON_BASE[13:4]) &&
                  (up_raddr_i[3:0] <= REG_CHAN_COUNT);

    // converters held in reset until software releases them
    assign adc_rst_o = ~adc_rstn;

    always_ff @(posedge up_clk)
    begin
        if (!up_rstn)
        begin
            up_wack_o  <= 1'b0;
            up_rack_o  <= 1'b0;
            up_rdata_o <= '0;
            scratch    <= '0;
            adc_rstn   <= 1'b0;
        end
        else
        begin
            up_wack_o <= up_wreq_i && wsel;
            up_rack_o <= up_rreq_i && rsel;
            if (up_wreq_i && wsel && (up_waddr_i[3:0] == REG_SCRATCH))
            begin
                scratch <= up_wdata_i;
            end
            if (up_wreq_i && wsel && (up_waddr_i[3:0] == REG_ADC_RSTN))
            begin
                adc_rstn <= up_wdata_i[0];
            end
            if (up_rreq_i && rsel)
            begin
                case (up_raddr_i[3:0])
                    REG_VERSION:  up_rdata_o <= MC_VERSION;
                    REG_SCRATCH:  up_rdata_o <= scratch;
                    REG_ADC_RSTN: up_rdata_o <= {31'd0, adc_rstn};
                    default:      up_rdata_o <= up_data_t'(MC_NUM_CHANNELS);
                endcase
            end
            else
            begin
                up_rdata_o <= '0;
            end
        end
    end

endmodule

// File: source/up_mc_channel.sv
// per channel registers: enable, last decimated word, sticky status

`timescale 1ns/1ps

module up_mc_channel
    import mc_current_pkg::*;
#(
    parameter int CHANNEL_ID = 0
) (
    input  logic     up_clk,
    input  logic     up_rstn,
    input  logic     up_wreq_i,
    input  up_addr_t up_waddr_i,
    input  up_data_t up_wdata_i,
    output logic     up_wack_o,
    input  logic     up_rreq_i,
    input  up_addr_t up_raddr_i,
    output up_data_t up_rdata_o,
    output logic     up_rack_o,
    input  sample_t  adc_data_i,
    input  logic     adc_data_ready_i,
    output logic     adc_enable_o
);

    localparam up_addr_t CHAN_BASE = MC_CHAN_BASE + up_addr_t'(16 * CHANNEL_ID);

    logic    wsel;
    logic    rsel;
    logic    wr_ctrl;
    sample_t data_hold;
    logic    status;

    // window match and a mapped offset
    assign wsel = (up_waddr_i[13:4] == CHAN_BASE[13:4]) && (up_waddr_i[3:0] <= REG_CHAN_STATUS);
    assign rsel = (up_raddr_i[13:4] == CHAN_BASE[13:4]) && (up_raddr_i[3:0] <= REG_CHAN_STATUS);
    assign wr_ctrl = up_wreq_i && wsel && (up_waddr_i[3:0] == REG_CHAN_CTRL);

    always_ff @(posedge up_clk)
    begin
        if (!up_rstn)
        begin
            up_wack_o    <= 1'b0;
            up_rack_o    <= 1'b0;
            up_rdata_o   <= '0;
            adc_enable_o <= 1'b0;
            data_hold    <= '0;
            status       <= 1'b0;
        end
        else
        begin
            up_wack_o <= up_wreq_i && wsel;
            up_rack_o <= up_rreq_i && rsel;
            if (wr_ctrl)
            begin
                adc_enable_o <= up_wdata_i[0];
            end
            if (adc_data_ready_i)
            begin
                data_hold <= adc_data_i;
            end
            // disabling clears status, even against a word in flight
            if (wr_ctrl && !up_wdata_i[0])
            begin
                status <= 1'b0;
            end
            else if (adc_data_ready_i)
            begin
                status <= 1'b1;
            end
            if (up_rreq_i && rsel)
            begin
                case (up_raddr_i[3:0])
                    REG_CHAN_CTRL:   up_rdata_o <= {31'd0, adc_enable_o};
                    REG_CHAN_DATA:   up_rdata_o <= {16'd0, data_hold};
                    default:         up_rdata_o <= {31'd0, status};
                endcase
            end
            else
            begin
                up_rdata_o <= '0;
            end
        end
    end

endmodule

// File: source/mc_sinc3_filter.sv
// third-order sinc decimator for one modulator bitstream
// drops the first two words after start, clamps full scale to max code

`timescale 1ns/1ps

module mc_sinc3_filter
    import mc_current_pkg::*;
#(
    parameter int DEC_RATE = 32
) (
    input  logic    up_clk,
    input  logic    up_rstn,
    input  logic    adc_rst_i,
    input  logic    enable_i,
    input  logic    bit_strobe_i,
    input  logic    adc_mdata_i,
    output sample_t data_o,
    output logic    data_ready_o
);

    localparam int DEC_W = $clog2(DEC_RATE);
    // large enough for DEC_RATE cubed
    localparam int ACC_W = 3 * DEC_W + 1;
    localparam logic [DEC_W-1:0] DEC_LAST   = DEC_W'(DEC_RATE - 1);
    localparam logic [ACC_W-1:0] FULL_SCALE = ACC_W'(DEC_RATE * DEC_RATE * DEC_RATE);

    filt_state_e      state;
    logic             run;
    logic             clear;
    logic             word_done;
    logic             warm_cnt;
    logic [DEC_W-1:0] dec_cnt;
    logic [ACC_W-1:0] int1;
    logic [ACC_W-1:0] int2;
    logic [ACC_W-1:0] int3;
    logic [ACC_W-1:0] int3_nxt;
    logic [ACC_W-1:0] int3_d;
    logic [ACC_W-1:0] comb1;
    logic [ACC_W-1:0] comb1_d;
    logic [ACC_W-1:0] comb2;
    logic [ACC_W-1:0] comb2_d;
    logic [ACC_W-1:0] comb3;
    sample_t          word_sat;

    assign run       = enable_i & ~adc_rst_i;
    assign clear     = ~run | (state == FILT_IDLE);
    assign word_done = bit_strobe_i & (dec_cnt == DEC_LAST);

    // comb works on the integrator value of the completing strobe
    assign int3_nxt = int3 + int2;
    assign comb1    = int3_nxt - int3_d;
    assign comb2    = comb1 - comb1_d;
    assign comb3    = comb2 - comb2_d;
    assign word_sat = (comb3 >= FULL_SCALE) ? '1 : sample_t'(comb3);

    // **************************************************
    // integrators and comb delays
    // **************************************************

    always_ff @(posedge up_clk)
    begin
        if (clear)
        begin
            int1    <= '0;
            int2    <= '0;
            int3    <= '0;
            int3_d  <= '0;
            comb1_d <= '0;
            comb2_d <= '0;
        end
        else if (bit_strobe_i)
        begin
            int1 <= int1 + ACC_W'(adc_mdata_i);
            int2 <= int2 + int1;
            int3 <= int3_nxt;
            if (word_done)
            begin
                int3_d  <= int3_nxt;
                comb1_d <= comb1;
                comb2_d <= comb2;
            end
        end
    end

    // **************************************************
    // state machine and output word
    // **************************************************

    always_ff @(posedge up_clk)
    begin
        if (!up_rstn)
        begin
            state        <= FILT_IDLE;
            dec_cnt      <= '0;
            warm_cnt     <= 1'b0;
            data_o       <= '0;
            data_ready_o <= 1'b0;
        end
        else
        begin
            data_ready_o <= 1'b0;
            if (clear)
            begin
                state    <= run ? FILT_WARMUP : FILT_IDLE;
                dec_cnt  <= '0;
                warm_cnt <= 1'b0;
            end
            else if (bit_strobe_i)
            begin
                // wraps at DEC_RATE, a power of two
                dec_cnt <= dec_cnt + 1'b1;
                if (word_done)
                begin
                    case (state)
                        FILT_WARMUP:
                        begin
                            warm_cnt <= 1'b1;
                            if (warm_cnt)
                            begin
                                state <= FILT_RUN;
                            end
                        end
                        FILT_RUN:
                        begin
                            data_o       <= word_sat;
                            data_ready_o <= 1'b1;
                        end
                        default:
                        begin
                            state <= FILT_IDLE;
                        end
                    endcase
                end
            end
        end
    end

endmodule

// File: source/mc_adc_clk_gen.sv
// modulator bit clock divider with a sample strobe on its rising edge

`timescale 1ns/1ps

module mc_adc_clk_gen #(
    parameter int ADC_CLK_DIV = 4
) (
    input  logic up_clk,
    input  logic up_rstn,
    output logic adc_clk_o,
    output logic bit_strobe_o
);

    localparam int CNT_W = (ADC_CLK_DIV > 2) ? $clog2(ADC_CLK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(ADC_CLK_DIV - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(ADC_CLK_DIV / 2);

    logic [CNT_W-1:0] div_cnt;
    logic [CNT_W-1:0] div_cnt_nxt;

    assign div_cnt_nxt = (div_cnt == CNT_LAST) ? '0 : div_cnt + 1'b1;

    // clock is high for the first half of each count period
    always_ff @(posedge up_clk)
    begin
        if (!up_rstn)
        begin
            div_cnt      <= CNT_LAST;
            adc_clk_o    <= 1'b0;
            bit_strobe_o <= 1'b0;
        end
        else
        begin
            div_cnt      <= div_cnt_nxt;
            adc_clk_o    <= (div_cnt_nxt < CNT_HALF);
            bit_strobe_o <= (div_cnt == CNT_LAST);
        end
    end

endmodule

// File: source/mc_current_pkg.sv
// shared widths and register map of the current monitor
// version constant and sinc filter state encoding

package mc_current_pkg;

    // processor bus
    typedef logic [13:0] up_addr_t;
    typedef logic [31:0] up_data_t;

    // decimated converter word, unsigned
    typedef logic [15:0] sample_t;

    localparam up_data_t MC_VERSION      = 32'h0001_0061;
    localparam int       MC_NUM_CHANNELS = 3;

    // **************************************************
    // register map
    // **************************************************

    localparam up_addr_t MC_COMMON_BASE = 14'h0000;
    localparam up_addr_t MC_CHAN_BASE   = 14'h0100;

    // common block word offsets
    localparam logic [3:0] REG_VERSION    = 4'h0;
    localparam logic [3:0] REG_SCRATCH    = 4'h1;
    localparam logic [3:0] REG_ADC_RSTN   = 4'h2;
    localparam logic [3:0] REG_CHAN_COUNT = 4'h3;

    // per channel word offsets
    localparam logic [3:0] REG_CHAN_CTRL   = 4'h0;
    localparam logic [3:0] REG_CHAN_DATA   = 4'h1;
    localparam logic [3:0] REG_CHAN_STATUS = 4'h2;

    typedef enum logic [1:0] {FILT_IDLE, FILT_WARMUP, FILT_RUN} filt_state_e;

endpackage
